/* rtl/pad_tap_cfg.svh */
////////////////////////////////////////////////////////////////////////////
// Sizes for the controller-port section. The port index must be able
// to address one slot past the last port, which reads as an idle pad.
////////////////////////////////////////////////////////////////////////////

`ifndef PAD_TAP_CFG_SVH
`define PAD_TAP_CFG_SVH

// Ports reachable through the Turbo Tap
`define PAD_NUM_PORTS 5

// Host joystick word, directions in 3:0, buttons above
`define PAD_JOY_W 12

// Console pad word, four active-low nibbles
`define PAD_WORD_W 16

// Port index counter, wraps at 7
`define PAD_IDX_W 3

`endif

/* rtl/pad_tap_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Types shared by the pad tap blocks. Pad words are active low.
////////////////////////////////////////////////////////////////////////////

`include "pad_tap_cfg.svh"

package pad_tap_pkg;

	// One port's word: {id, III-VI, buttons, directions}
	typedef logic [`PAD_WORD_W-1:0] pad_word_t;

	// Indices at or above the port count read no pad
	typedef logic [`PAD_IDX_W-1:0] port_idx_t;

	// All port words side by side, as fed to the nibble mux
	typedef pad_word_t pad_bank_t [`PAD_NUM_PORTS];

	// Nibble currently presented, encoded as {high_page, sel}
	typedef enum logic [1:0] {
		NIB_DIR = 2'd0,
		NIB_BTN = 2'd1,
		NIB_EXT = 2'd2,
		NIB_ID  = 2'd3
	} nib_sel_t;

	// Nothing pressed, six-button id nibble reads zero
	localparam pad_word_t PAD_IDLE_WORD = 16'h0FFF;

endpackage

/* rtl/tap_if.sv */
////////////////////////////////////////////////////////////////////////////
// Scan state of the tap. Levels are the registered SEL/CLR pins, so they
// trail the connector by one clock.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface tap_if;

	// Port currently addressed by the tap
	pad_tap_pkg::port_idx_t port_idx;

	// Extra-button page of the six-button protocol
	logic high_page;

	// Registered pin levels
	logic sel_lvl;
	logic clr_lvl;

	modport source (
		output port_idx,
		output high_page,
		output sel_lvl,
		output clr_lvl
	);

	modport sink (
		input port_idx,
		input high_page,
		input sel_lvl,
		input clr_lvl
	);

endinterface

/* rtl/tap_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Follows the console's SEL/CLR lines. SEL and CLR are taken as already
// synchronous to clk_sys; edges are found against the registered levels.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tap_sequencer (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  sel,
	input  logic  clr,
	input  logic  tap_en,
	input  logic  six_btn_en,
	tap_if.source tap,
	output logic  snapshot
);

	logic sel_lvl;
	logic clr_lvl;
	logic sel_rise;
	logic clr_rise;
	logic high_page;
	pad_tap_pkg::port_idx_t port_idx;

	// Pin against last registered level
	assign sel_rise = sel & ~sel_lvl;
	assign clr_rise = clr & ~clr_lvl;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_lvl   <= 1'b0;
			clr_lvl   <= 1'b0;
			snapshot  <= 1'b0;
			high_page <= 1'b0;
			port_idx  <= '0;
		end else begin
			sel_lvl  <= sel;
			clr_lvl  <= clr;
			snapshot <= clr_rise;

			// Each CLR pulse toggles the page in six-button mode
			if (clr_rise) begin
				high_page <= ~high_page & six_btn_en;
			end

			// CLR parks the tap on port 0 and SEL steps it
			if (clr_lvl) begin
				port_idx <= '0;
			end else if (sel_rise && !clr && tap_en) begin
				port_idx <= port_idx + pad_tap_pkg::port_idx_t'(1);
			end
		end
	end

	assign tap.port_idx  = port_idx;
	assign tap.high_page = high_page;
	assign tap.sel_lvl   = sel_lvl;
	assign tap.clr_lvl   = clr_lvl;

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// A scan always restarts from the first port after CLR
	a_clr_home: assert property (
		@(posedge clk_sys) disable iff (reset)
		clr_lvl |=> (tap.port_idx == '0)
	);

endmodule

/* rtl/pad_port.sv */
////////////////////////////////////////////////////////////////////////////
// One controller port. Holds the pad word taken at the last snapshot;
// joystick changes in between stay invisible to the console.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_tap_cfg.svh"

module pad_port (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [`PAD_JOY_W-1:0]  joy,
	input  logic                   snapshot,
	output pad_tap_pkg::pad_word_t word
);

	pad_tap_pkg::pad_word_t remap;

	// Host order to connector order, inverted to active low
	// buttons nibble is II, Select, I, Run from the top bit down
	always_comb begin
		remap[15:12] = 4'h0;
		remap[11:8]  = ~joy[11:8];
		remap[7:4]   = ~{joy[5], joy[6], joy[4], joy[7]};
		remap[3:0]   = ~joy[3:0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			word <= pad_tap_pkg::PAD_IDLE_WORD;
		end else if (snapshot) begin
			word <= remap;
		end
	end

endmodule

/* rtl/nibble_mux.sv */
////////////////////////////////////////////////////////////////////////////
// Drives the 4-bit connector nibble. Output is registered and held at
// zero while CLR is high; unpopulated tap slots read as an idle pad.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_tap_cfg.svh"

module nibble_mux (
	input  logic                   clk_sys,
	input  logic                   reset,
	tap_if.sink                    tap,
	input  pad_tap_pkg::pad_bank_t words,
	output logic [3:0]             pad_nibble
);

	pad_tap_pkg::nib_sel_t  nib_sel;
	pad_tap_pkg::pad_word_t word;
	logic [3:0]             nib;

	assign nib_sel = pad_tap_pkg::nib_sel_t'({tap.high_page, tap.sel_lvl});

	// Port select, slots past the last port have no pad
	always_comb begin
		if (tap.port_idx < pad_tap_pkg::port_idx_t'(`PAD_NUM_PORTS)) begin
			word = words[tap.port_idx];
		end else begin
			word = pad_tap_pkg::PAD_IDLE_WORD;
		end
	end

	always_comb begin
		case (nib_sel)
			pad_tap_pkg::NIB_DIR: nib = word[3:0];
			pad_tap_pkg::NIB_BTN: nib = word[7:4];
			pad_tap_pkg::NIB_EXT: nib = word[11:8];
			default:              nib = word[15:12];
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset || tap.clr_lvl) begin
			pad_nibble <= 4'h0;
		end else begin
			pad_nibble <= nib;
		end
	end

	// Console sees all lines low during CLR
	a_clr_zero: assert property (
		@(posedge clk_sys) disable iff (reset)
		tap.clr_lvl |=> (pad_nibble == 4'h0)
	);

endmodule

/* rtl/pad_tap_top.sv */
////////////////////////////////////////////////////////////////////////////
// Controller-port section: five host pads behind a Turbo Tap, with the
// six-button protocol. A pin change shows on pad_nibble within 3 clocks.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_tap_cfg.svh"

module pad_tap_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`PAD_JOY_W-1:0] joy_0,
	input  logic [`PAD_JOY_W-1:0] joy_1,
	input  logic [`PAD_JOY_W-1:0] joy_2,
	input  logic [`PAD_JOY_W-1:0] joy_3,
	input  logic [`PAD_JOY_W-1:0] joy_4,
	input  logic                  sel,
	input  logic                  clr,
	input  logic                  tap_en,
	input  logic                  six_btn_en,
	output logic [3:0]            pad_nibble
);

	logic [`PAD_JOY_W-1:0]  joy [`PAD_NUM_PORTS];
	logic                   snapshot;
	pad_tap_pkg::pad_bank_t words;

	tap_if tap ();

	assign joy = '{joy_0, joy_1, joy_2, joy_3, joy_4};

	////////////////////////////////////////////////////////////////////////////
	// SEL/CLR tracking
	////////////////////////////////////////////////////////////////////////////

	tap_sequencer u_sequencer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sel        (sel),
		.clr        (clr),
		.tap_en     (tap_en),
		.six_btn_en (six_btn_en),
		.tap        (tap.source),
		.snapshot   (snapshot)
	);

	////////////////////////////////////////////////////////////////////////////
	// Ports and output mux
	////////////////////////////////////////////////////////////////////////////

	// All ports share one snapshot so a scan reads one frame
	for (genvar i = 0; i < `PAD_NUM_PORTS; i++) begin : g_port
		pad_port u_port (
			.clk_sys  (clk_sys),
			.reset    (reset),
			.joy      (joy[i]),
			.snapshot (snapshot),
			.word     (words[i])
		);
	end

	nibble_mux u_mux (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.tap        (tap.sink),
		.words      (words),
		.pad_nibble (pad_nibble)
	);

endmodule

/* sim/pad_tap_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for pad_tap_top. Every pin pattern is held for 4 clocks and
// the settled nibble is compared with a model of the tap protocol.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pad_tap_cfg.svh"

module pad_tap_tb;

	localparam int RESET_CYCLES   = 3;
	localparam int STEP_CYCLES    = 4;
	// Upper bound on the directed steps below
	localparam int DIRECTED_STEPS = 40;
	localparam int RANDOM_STEPS   = 200;
	localparam int MAX_CYCLES     =
		2 * (RESET_CYCLES + STEP_CYCLES * (DIRECTED_STEPS + RANDOM_STEPS));
	localparam logic [15:0] IDLE_WORD = 16'h0FFF;

	logic                  clk_sys;
	logic                  reset;
	logic [`PAD_JOY_W-1:0] joy_0;
	logic [`PAD_JOY_W-1:0] joy_1;
	logic [`PAD_JOY_W-1:0] joy_2;
	logic [`PAD_JOY_W-1:0] joy_3;
	logic [`PAD_JOY_W-1:0] joy_4;
	logic                  sel;
	logic                  clr;
	logic                  tap_en;
	logic                  six_btn_en;
	logic [3:0]            pad_nibble;

	// Joystick values that go out with the next pattern
	logic [`PAD_JOY_W-1:0] joy_val [`PAD_NUM_PORTS];

	// Model state
	logic [15:0] m_snap [`PAD_NUM_PORTS];
	logic [2:0]  m_idx;
	logic        m_page;
	logic        m_prev_sel;
	logic        m_prev_clr;

	logic [15:0] lfsr_state;
	int          cycle_count;
	int          checks;
	int          errors;

	pad_tap_top dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.joy_2      (joy_2),
		.joy_3      (joy_3),
		.joy_4      (joy_4),
		.sel        (sel),
		.clr        (clr),
		.tap_en     (tap_en),
		.six_btn_en (six_btn_en),
		.pad_nibble (pad_nibble)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Random source and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		random_bits = r;
	endfunction

	// Active-low connector word with a zero id nibble on top
	function automatic logic [15:0] pad_word(input logic [11:0] j);
		logic [3:0] dirs;
		logic [3:0] btns;
		logic [3:0] ext;
		dirs = j[3:0];
		ext  = j[11:8];
		// Connector order from the top bit down is II, Select, I, Run
		btns[3] = j[5];
		btns[2] = j[6];
		btns[1] = j[4];
		btns[0] = j[7];
		pad_word = ~{4'hF, ext, btns, dirs};
	endfunction

	task automatic randomize_joys();
		logic [31:0] r;
		for (int i = 0; i < `PAD_NUM_PORTS; i++) begin
			r = random_bits(12);
			joy_val[i] = r[11:0];
		end
	endtask

	task automatic model_update(input logic s, input logic c, input logic t, input logic x);
		if (c && !m_prev_clr) begin
			for (int i = 0; i < `PAD_NUM_PORTS; i++) begin
				m_snap[i] = pad_word(joy_val[i]);
			end
			m_page = x ? ~m_page : 1'b0;
		end
		// A SEL rise right as CLR drops is swallowed by the CLR hold
		if (c) begin
			m_idx = 3'd0;
		end else if (s && !m_prev_sel && t && !m_prev_clr) begin
			m_idx = m_idx + 3'd1;
		end
		m_prev_sel = s;
		m_prev_clr = c;
	endtask

	function automatic logic [3:0] model_nibble(input logic s, input logic c);
		logic [15:0] w;
		w = (m_idx < `PAD_NUM_PORTS) ? m_snap[m_idx] : IDLE_WORD;
		if (c) begin
			model_nibble = 4'h0;
		end else begin
			case ({m_page, s})
				2'd0:    model_nibble = w[3:0];
				2'd1:    model_nibble = w[7:4];
				2'd2:    model_nibble = w[11:8];
				default: model_nibble = w[15:12];
			endcase
		end
	endfunction

	// Drive one pattern, hold it, check the settled nibble on the last cycle
	task automatic apply_step(input logic s, input logic c, input logic t, input logic x);
		logic [3:0] expected;
		@(posedge clk_sys);
		sel        <= s;
		clr        <= c;
		tap_en     <= t;
		six_btn_en <= x;
		joy_0      <= joy_val[0];
		joy_1      <= joy_val[1];
		joy_2      <= joy_val[2];
		joy_3      <= joy_val[3];
		joy_4      <= joy_val[4];
		model_update(s, c, t, x);
		expected = model_nibble(s, c);
		repeat (STEP_CYCLES - 1) @(posedge clk_sys);
		@(negedge clk_sys);
		checks++;
		assert (pad_nibble === expected) else begin
			errors++;
			$display("CHECK FAILED: pad_nibble expected %h actual %h", expected, pad_nibble);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : main
		logic [31:0] r;
		reset      = 1'b1;
		sel        = 1'b0;
		clr        = 1'b0;
		tap_en     = 1'b0;
		six_btn_en = 1'b0;
		joy_0      = '0;
		joy_1      = '0;
		joy_2      = '0;
		joy_3      = '0;
		joy_4      = '0;
		lfsr_state = 16'd20;
		checks     = 0;
		errors     = 0;
		m_idx      = 3'd0;
		m_page     = 1'b0;
		m_prev_sel = 1'b0;
		m_prev_clr = 1'b0;
		for (int i = 0; i < `PAD_NUM_PORTS; i++) begin
			joy_val[i] = '0;
			m_snap[i]  = IDLE_WORD;
		end
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;

		// Idle pad straight out of reset
		apply_step(1'b0, 1'b0, 1'b0, 1'b0);

		// Single pad on the normal page
		randomize_joys();
		apply_step(1'b0, 1'b1, 1'b0, 1'b0);
		apply_step(1'b0, 1'b0, 1'b0, 1'b0);
		apply_step(1'b1, 1'b0, 1'b0, 1'b0);

		// Turbo Tap walk past the last port
		apply_step(1'b0, 1'b1, 1'b1, 1'b0);
		apply_step(1'b0, 1'b0, 1'b1, 1'b0);
		for (int i = 0; i < `PAD_NUM_PORTS; i++) begin
			apply_step(1'b1, 1'b0, 1'b1, 1'b0);
			apply_step(1'b0, 1'b0, 1'b1, 1'b0);
		end
		// SEL must not move the index with the tap off
		apply_step(1'b0, 1'b1, 1'b0, 1'b0);
		apply_step(1'b0, 1'b0, 1'b0, 1'b0);
		apply_step(1'b1, 1'b0, 1'b0, 1'b0);
		apply_step(1'b0, 1'b0, 1'b0, 1'b0);
		apply_step(1'b1, 1'b0, 1'b0, 1'b0);

		// Six-button paging
		for (int p = 0; p < 4; p++) begin
			apply_step(1'b0, 1'b1, 1'b0, 1'b1);
			apply_step(1'b0, 1'b0, 1'b0, 1'b1);
			apply_step(1'b1, 1'b0, 1'b0, 1'b1);
		end

		// Snapshot hold across joystick changes
		apply_step(1'b0, 1'b1, 1'b0, 1'b0);
		apply_step(1'b0, 1'b0, 1'b0, 1'b0);
		randomize_joys();
		apply_step(1'b0, 1'b0, 1'b0, 1'b0);
		apply_step(1'b1, 1'b0, 1'b0, 1'b0);
		apply_step(1'b0, 1'b1, 1'b0, 1'b0);
		apply_step(1'b0, 1'b0, 1'b0, 1'b0);

		// Random pin traffic with CLR about one step in eight
		for (int n = 0; n < RANDOM_STEPS; n++) begin
			r = random_bits(10);
			if (r[2:0] == 3'd0) begin
				randomize_joys();
			end
			apply_step(r[3], r[6:4] == 3'd0, r[9:8] != 2'd0, r[7]);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* pad_tap.f */
+incdir+rtl
rtl/pad_tap_pkg.sv
rtl/tap_if.sv
rtl/tap_sequencer.sv
rtl/pad_port.sv
rtl/nibble_mux.sv
rtl/pad_tap_top.sv
sim/pad_tap_tb.sv

/* Bender.yml */
package:
  name: pad_tap

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pad_tap_pkg.sv
      - rtl/tap_if.sv
      - rtl/tap_sequencer.sv
      - rtl/pad_port.sv
      - rtl/nibble_mux.sv
      - rtl/pad_tap_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/pad_tap_tb.sv
